// File: alu_station.sv
`timescale 1ns/1ns

module alu_station #(
    parameter sb_pkg::unit_t UNIT_ID = sb_pkg::unit_alu0
) (
    input logic clk,
    input logic resetn,
    dispatch_if.station win,
    complete_if.station cpl,
    retire_if.station ret,
    rf_read_if.station rd_port
);

    logic busy;
    logic issued;
    logic done;
    sb_pkg::reg_stat_t wait1;
    sb_pkg::reg_stat_t wait2;

    sb_pkg::tag_t tag;
    sb_pkg::alu_op_t op;
    sb_pkg::reg_addr_t rs1;
    sb_pkg::reg_addr_t rs2;
    logic rs1_en;
    logic rs2_en;
    logic [15:0] imm;
    sb_pkg::word_t result;

    sb_pkg::word_t opnd_a;
    sb_pkg::word_t opnd_b;
    sb_pkg::word_t alu_out;
    logic load;
    logic ready;

    assign load = win.dispatch & (win.head_inst.unit == UNIT_ID);
    assign ready = busy & ~issued & ~wait1.pending & ~wait2.pending;

    assign rd_port.addr_a = rs1;
    assign rd_port.addr_b = rs2;
    assign opnd_a = rs1_en ? rd_port.data_a : '0;
    assign opnd_b = rs2_en ? rd_port.data_b : sb_pkg::word_t'($signed(imm));

    always_comb begin
        case (op)
            sb_pkg::op_add: alu_out = opnd_a + opnd_b;
            sb_pkg::op_sub: alu_out = opnd_a - opnd_b;
            sb_pkg::op_and: alu_out = opnd_a & opnd_b;
            sb_pkg::op_or:  alu_out = opnd_a | opnd_b;
            sb_pkg::op_xor: alu_out = opnd_a ^ opnd_b;
            sb_pkg::op_slt: alu_out = sb_pkg::word_t'($signed(opnd_a) < $signed(opnd_b));
            sb_pkg::op_sll: alu_out = opnd_a << opnd_b[4:0];
            default:        alu_out = opnd_a >> opnd_b[4:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            issued <= 1'b0;
            done <= 1'b0;
            wait1 <= '0;
            wait2 <= '0;
        end else begin
            done <= ready;
            if (ready) begin
                issued <= 1'b1;
            end
            if (ret.retire && wait1.unit == ret.unit) begin
                wait1.pending <= 1'b0;
            end
            if (ret.retire && wait2.unit == ret.unit) begin
                wait2.pending <= 1'b0;
            end
            // entry held until its own retire
            if (ret.retire && ret.unit == UNIT_ID) begin
                busy <= 1'b0;
            end
            if (load) begin
                busy <= 1'b1;
                issued <= 1'b0;
                wait1 <= win.src1_stat;
                wait2 <= win.src2_stat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tag <= win.head_tag;
            op <= win.head_inst.op;
            rs1 <= win.head_inst.rs1;
            rs2 <= win.head_inst.rs2;
            rs1_en <= win.head_inst.rs1_en;
            rs2_en <= win.head_inst.rs2_en;
            imm <= win.head_inst.imm;
        end
        if (ready) begin
            result <= alu_out;
        end
    end

    assign cpl.done = done;
    assign cpl.tag = tag;
    assign cpl.result = result;
    assign cpl.busy = busy;

endmodule

// File: dispatch_ctrl.sv
`timescale 1ns/1ns
`include "sb_macros.svh"

module dispatch_ctrl (
    input logic clk,
    input logic resetn,
    dispatch_if.ctrl win,
    complete_if.ctrl cpl0,
    complete_if.ctrl cpl1,
    retire_if.ctrl ret
);

    sb_pkg::reg_stat_t stat_tab [`SB_NUM_REGS];
    logic unit_busy;
    logic rd_pending;

    // a producer retiring this cycle is already in the register file
    function automatic sb_pkg::reg_stat_t src_lookup(
        input sb_pkg::reg_stat_t stat,
        input sb_pkg::reg_addr_t ra,
        input logic en,
        input logic retire,
        input sb_pkg::reg_addr_t ret_rd,
        input sb_pkg::unit_t ret_unit
    );
        sb_pkg::reg_stat_t st;
        st = stat;
        if (!en) begin
            st.pending = 1'b0;
        end
        if (retire && ret_rd == ra && ret_unit == stat.unit) begin
            st.pending = 1'b0;
        end
        return st;
    endfunction

    assign unit_busy = (win.head_inst.unit == sb_pkg::unit_alu0) ? cpl0.busy : cpl1.busy;
    assign rd_pending = stat_tab[win.head_inst.rd].pending;
    assign win.dispatch = win.head_valid & ~unit_busy & ~rd_pending;

    assign win.src1_stat = src_lookup(stat_tab[win.head_inst.rs1], win.head_inst.rs1,
                                      win.head_inst.rs1_en, ret.retire, ret.rd, ret.unit);
    assign win.src2_stat = src_lookup(stat_tab[win.head_inst.rs2], win.head_inst.rs2,
                                      win.head_inst.rs2_en, ret.retire, ret.rd, ret.unit);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `SB_NUM_REGS; i++) begin
                stat_tab[i] <= '0;
            end
        end else begin
            if (ret.retire && stat_tab[ret.rd].unit == ret.unit) begin
                stat_tab[ret.rd].pending <= 1'b0;
            end
            // r0 never gets a pending writer
            if (win.dispatch && win.head_inst.rd != '0) begin
                stat_tab[win.head_inst.rd].pending <= 1'b1;
                stat_tab[win.head_inst.rd].unit <= win.head_inst.unit;
            end
        end
    end

endmodule

// File: inst_window.sv
`timescale 1ns/1ns
`include "sb_macros.svh"

module inst_window (
    input  logic clk,
    input  logic resetn,
    input  logic inst_valid,
    input  sb_pkg::inst_t inst,
    output logic stall,
    dispatch_if.window win,
    complete_if.window cpl0,
    complete_if.window cpl1,
    retire_if.window ret
);

    localparam int CNT_W = $clog2(`SB_WINDOW_DEPTH) + 1;

    sb_pkg::inst_t inst_mem [`SB_WINDOW_DEPTH];
    sb_pkg::word_t result_mem [`SB_WINDOW_DEPTH];

    logic [`SB_WINDOW_DEPTH-1:0] valid;
    logic [`SB_WINDOW_DEPTH-1:0] dispatched;
    logic [`SB_WINDOW_DEPTH-1:0] complete;

    sb_pkg::tag_t tail;
    sb_pkg::tag_t disp_ptr;
    sb_pkg::tag_t head;
    logic [CNT_W-1:0] count;
    logic accept;

    // registered occupancy only
    assign stall = count >= CNT_W'(`SB_STALL_LEVEL);
    assign accept = inst_valid & ~stall;

    // dispatch candidate
    assign win.head_valid = valid[disp_ptr] & ~dispatched[disp_ptr];
    assign win.head_tag = disp_ptr;
    assign win.head_inst = inst_mem[disp_ptr];

    // in-order retire candidate
    assign ret.retire = valid[head] & complete[head];
    assign ret.pc = inst_mem[head].pc;
    assign ret.rd = inst_mem[head].rd;
    assign ret.unit = inst_mem[head].unit;
    assign ret.result = result_mem[head];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= '0;
            dispatched <= '0;
            complete <= '0;
            tail <= '0;
            disp_ptr <= '0;
            head <= '0;
            count <= '0;
        end else begin
            if (accept) begin
                valid[tail] <= 1'b1;
                dispatched[tail] <= 1'b0;
                complete[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (win.dispatch) begin
                dispatched[disp_ptr] <= 1'b1;
                disp_ptr <= disp_ptr + 1'b1;
            end
            if (cpl0.done) begin
                complete[cpl0.tag] <= 1'b1;
            end
            if (cpl1.done) begin
                complete[cpl1.tag] <= 1'b1;
            end
            if (ret.retire) begin
                valid[head] <= 1'b0;
                head <= head + 1'b1;
            end
            count <= count + CNT_W'(accept) - CNT_W'(ret.retire);
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_mem[tail] <= inst;
        end
        if (cpl0.done) begin
            result_mem[cpl0.tag] <= cpl0.result;
        end
        if (cpl1.done) begin
            result_mem[cpl1.tag] <= cpl1.result;
        end
    end

endmodule

// File: list.f
+incdir+.
sb_pkg.sv
sb_ifs.sv
inst_window.sv
dispatch_ctrl.sv
alu_station.sv
retire_regfile.sv
scoreboard_top.sv
tb_scoreboard.sv

// File: retire_regfile.sv
`timescale 1ns/1ns
`include "sb_macros.svh"

module retire_regfile (
    input  logic clk,
    input  logic resetn,
    retire_if.regfile ret,
    rf_read_if.regfile rd0,
    rf_read_if.regfile rd1,
    output sb_pkg::word_t debug_wb_pc,
    output logic debug_wb_rf_wen,
    output sb_pkg::reg_addr_t debug_wb_rf_wnum,
    output sb_pkg::word_t debug_wb_rf_wdata
);

    sb_pkg::word_t regs [`SB_NUM_REGS];

    // r0 reads as zero
    assign rd0.data_a = (rd0.addr_a == '0) ? '0 : regs[rd0.addr_a];
    assign rd0.data_b = (rd0.addr_b == '0) ? '0 : regs[rd0.addr_b];
    assign rd1.data_a = (rd1.addr_a == '0) ? '0 : regs[rd1.addr_a];
    assign rd1.data_b = (rd1.addr_b == '0) ? '0 : regs[rd1.addr_b];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `SB_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ret.retire && ret.rd != '0) begin
            regs[ret.rd] <= ret.result;
        end
    end

    // trace covers rd 0 as well
    always_ff @(posedge clk) begin
        if (!resetn) begin
            debug_wb_rf_wen <= 1'b0;
            debug_wb_pc <= '0;
            debug_wb_rf_wnum <= '0;
            debug_wb_rf_wdata <= '0;
        end else begin
            debug_wb_rf_wen <= ret.retire;
            if (ret.retire) begin
                debug_wb_pc <= ret.pc;
                debug_wb_rf_wnum <= ret.rd;
                debug_wb_rf_wdata <= ret.result;
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --top-module tb_scoreboard -f list.f -o tb_scoreboard > build.log 2>&1 &&
./obj_dir/tb_scoreboard > sim.log 2>&1
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL see build.log and sim.log"; exit 1; }

// File: sb_ifs.sv
`timescale 1ns/1ns

// window head to the dispatch logic and stations
interface dispatch_if;
    logic head_valid;
    sb_pkg::tag_t head_tag;
    sb_pkg::inst_t head_inst;
    logic dispatch;
    sb_pkg::reg_stat_t src1_stat;
    sb_pkg::reg_stat_t src2_stat;

    modport window(output head_valid, output head_tag, output head_inst, input dispatch);
    modport ctrl(input head_valid, input head_inst, output dispatch,
                 output src1_stat, output src2_stat);
    modport station(input dispatch, input head_tag, input head_inst,
                    input src1_stat, input src2_stat);
endinterface

// one per station
interface complete_if;
    logic done;
    sb_pkg::tag_t tag;
    sb_pkg::word_t result;
    logic busy;

    modport station(output done, output tag, output result, output busy);
    modport window(input done, input tag, input result);
    modport ctrl(input busy);
endinterface

// in-order retire broadcast
interface retire_if;
    logic retire;
    sb_pkg::word_t pc;
    sb_pkg::reg_addr_t rd;
    sb_pkg::word_t result;
    sb_pkg::unit_t unit;

    modport window(output retire, output pc, output rd, output result, output unit);
    modport ctrl(input retire, input rd, input unit);
    modport station(input retire, input unit);
    modport regfile(input retire, input pc, input rd, input result);
endinterface

// two combinational read ports per station
interface rf_read_if;
    sb_pkg::reg_addr_t addr_a;
    sb_pkg::reg_addr_t addr_b;
    sb_pkg::word_t data_a;
    sb_pkg::word_t data_b;

    modport station(output addr_a, output addr_b, input data_a, input data_b);
    modport regfile(input addr_a, input addr_b, output data_a, output data_b);
endinterface

// File: sb_macros.svh
`ifndef SB_MACROS_SVH
`define SB_MACROS_SVH

// instruction window
`define SB_WINDOW_DEPTH 8
`define SB_STALL_LEVEL 6

// execution resources
`define SB_NUM_UNITS 2

// architectural state
`define SB_NUM_REGS 32
`define SB_XLEN 32

`endif

// File: sb_pkg.sv
`include "sb_macros.svh"

package sb_pkg;

    typedef logic [$clog2(`SB_WINDOW_DEPTH)-1:0] tag_t;

    typedef enum logic [$clog2(`SB_NUM_UNITS)-1:0] {
        unit_alu0,
        unit_alu1
    } unit_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_sll,
        op_srl
    } alu_op_t;

    typedef logic [$clog2(`SB_NUM_REGS)-1:0] reg_addr_t;
    typedef logic [`SB_XLEN-1:0] word_t;

    typedef struct packed {
        word_t pc;
        unit_t unit;
        alu_op_t op;
        reg_addr_t rd;
        reg_addr_t rs1;
        logic rs1_en;
        reg_addr_t rs2;
        logic rs2_en;
        logic [15:0] imm;
    } inst_t;

    // pending writer of one register
    typedef struct packed {
        logic pending;
        unit_t unit;
    } reg_stat_t;

endpackage

// File: scoreboard_top.sv
`timescale 1ns/1ns

module scoreboard_top (
    input  logic clk,
    input  logic resetn,
    input  logic inst_valid,
    input  sb_pkg::word_t inst_pc,
    input  sb_pkg::unit_t inst_unit,
    input  sb_pkg::alu_op_t inst_op,
    input  sb_pkg::reg_addr_t inst_rd,
    input  sb_pkg::reg_addr_t inst_rs1,
    input  logic inst_rs1_en,
    input  sb_pkg::reg_addr_t inst_rs2,
    input  logic inst_rs2_en,
    input  logic [15:0] inst_imm,
    output logic stall,
    output sb_pkg::word_t debug_wb_pc,
    output logic debug_wb_rf_wen,
    output sb_pkg::reg_addr_t debug_wb_rf_wnum,
    output sb_pkg::word_t debug_wb_rf_wdata
);

    sb_pkg::inst_t inst;

    dispatch_if disp_bus ();
    complete_if cpl0 ();
    complete_if cpl1 ();
    retire_if ret_bus ();
    rf_read_if rd0 ();
    rf_read_if rd1 ();

    assign inst = '{pc: inst_pc, unit: inst_unit, op: inst_op, rd: inst_rd,
                    rs1: inst_rs1, rs1_en: inst_rs1_en, rs2: inst_rs2,
                    rs2_en: inst_rs2_en, imm: inst_imm};

    inst_window inst_window_inst (
        .clk        (clk),
        .resetn     (resetn),
        .inst_valid (inst_valid),
        .inst       (inst),
        .stall      (stall),
        .win        (disp_bus),
        .cpl0       (cpl0),
        .cpl1       (cpl1),
        .ret        (ret_bus)
    );

    dispatch_ctrl dispatch_ctrl_inst (
        .clk    (clk),
        .resetn (resetn),
        .win    (disp_bus),
        .cpl0   (cpl0),
        .cpl1   (cpl1),
        .ret    (ret_bus)
    );

    alu_station #(.UNIT_ID(sb_pkg::unit_alu0)) alu_station0_inst (
        .clk     (clk),
        .resetn  (resetn),
        .win     (disp_bus),
        .cpl     (cpl0),
        .ret     (ret_bus),
        .rd_port (rd0)
    );

    alu_station #(.UNIT_ID(sb_pkg::unit_alu1)) alu_station1_inst (
        .clk     (clk),
        .resetn  (resetn),
        .win     (disp_bus),
        .cpl     (cpl1),
        .ret     (ret_bus),
        .rd_port (rd1)
    );

    retire_regfile retire_regfile_inst (
        .clk               (clk),
        .resetn            (resetn),
        .ret               (ret_bus),
        .rd0               (rd0),
        .rd1               (rd1),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

// File: tb_scoreboard.sv
`timescale 1ns/1ns
`include "sb_macros.svh"

module tb_scoreboard;

    localparam int TIMEOUT = 2000;
    localparam sb_pkg::unit_t u0 = sb_pkg::unit_alu0;
    localparam sb_pkg::unit_t u1 = sb_pkg::unit_alu1;

    logic clk = 1'b0;
    logic resetn;
    logic inst_valid;
    sb_pkg::word_t inst_pc;
    sb_pkg::unit_t inst_unit;
    sb_pkg::alu_op_t inst_op;
    sb_pkg::reg_addr_t inst_rd;
    sb_pkg::reg_addr_t inst_rs1;
    logic inst_rs1_en;
    sb_pkg::reg_addr_t inst_rs2;
    logic inst_rs2_en;
    logic [15:0] inst_imm;
    logic stall;
    sb_pkg::word_t debug_wb_pc;
    logic debug_wb_rf_wen;
    sb_pkg::reg_addr_t debug_wb_rf_wnum;
    sb_pkg::word_t debug_wb_rf_wdata;

    // expected values come from the model
    sb_pkg::inst_t tbl_inst [$];
    sb_pkg::word_t tbl_val [$];
    sb_pkg::word_t model_regs [`SB_NUM_REGS];
    sb_pkg::word_t next_pc;

    // trace seen on the debug port
    sb_pkg::word_t mon_pc [$];
    sb_pkg::reg_addr_t mon_rd [$];
    sb_pkg::word_t mon_val [$];
    int stall_cycles = 0;

    int seed;
    int error_count;
    int test_count;
    int failed_tests;
    logic timed_out;

    scoreboard_top scoreboard_top_inst (
        .clk               (clk),
        .resetn            (resetn),
        .inst_valid        (inst_valid),
        .inst_pc           (inst_pc),
        .inst_unit         (inst_unit),
        .inst_op           (inst_op),
        .inst_rd           (inst_rd),
        .inst_rs1          (inst_rs1),
        .inst_rs1_en       (inst_rs1_en),
        .inst_rs2          (inst_rs2),
        .inst_rs2_en       (inst_rs2_en),
        .inst_imm          (inst_imm),
        .stall             (stall),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #2 clk = ~clk;

    // registered outputs are stable at the falling edge
    always @(negedge clk) begin
        if (resetn && debug_wb_rf_wen) begin
            mon_pc.push_back(debug_wb_pc);
            mon_rd.push_back(debug_wb_rf_wnum);
            mon_val.push_back(debug_wb_rf_wdata);
        end
        if (resetn && stall) begin
            stall_cycles = stall_cycles + 1;
        end
    end

    function automatic sb_pkg::word_t alu_model(input sb_pkg::alu_op_t op,
                                                input sb_pkg::word_t a,
                                                input sb_pkg::word_t b);
        sb_pkg::word_t r;
        case (op)
            sb_pkg::op_add: r = a + b;
            sb_pkg::op_sub: r = a - b;
            sb_pkg::op_and: r = a & b;
            sb_pkg::op_or:  r = a | b;
            sb_pkg::op_xor: r = a ^ b;
            sb_pkg::op_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            sb_pkg::op_sll: r = a << b[4:0];
            default:        r = a >> b[4:0];
        endcase
        return r;
    endfunction

    task automatic check_word(input string name, input sb_pkg::word_t exp,
                              input sb_pkg::word_t act);
        if (exp !== act) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_reg(input string name, input sb_pkg::reg_addr_t exp,
                             input sb_pkg::reg_addr_t act);
        if (exp !== act) begin
            $display("Error %s: expected r%0d, actual r%0d", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("PASS %s", name);
        end else begin
            failed_tests++;
            $display("FAIL %s with %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic add_row(input sb_pkg::unit_t unit, input sb_pkg::alu_op_t op,
                           input int rd, input int rs1, input logic rs1_en,
                           input int rs2, input logic rs2_en, input logic [15:0] imm);
        sb_pkg::inst_t row;
        row.pc = next_pc;
        row.unit = unit;
        row.op = op;
        row.rd = sb_pkg::reg_addr_t'(rd);
        row.rs1 = sb_pkg::reg_addr_t'(rs1);
        row.rs1_en = rs1_en;
        row.rs2 = sb_pkg::reg_addr_t'(rs2);
        row.rs2_en = rs2_en;
        row.imm = imm;
        tbl_inst.push_back(row);
        next_pc = next_pc + 32'd4;
    endtask

    // sequential reference of the register file
    task automatic fill_expected();
        sb_pkg::word_t a;
        sb_pkg::word_t b;
        sb_pkg::word_t v;
        foreach (tbl_inst[i]) begin
            a = tbl_inst[i].rs1_en ? model_regs[tbl_inst[i].rs1] : '0;
            b = tbl_inst[i].rs2_en ? model_regs[tbl_inst[i].rs2]
                                   : {{16{tbl_inst[i].imm[15]}}, tbl_inst[i].imm};
            v = alu_model(tbl_inst[i].op, a, b);
            tbl_val.push_back(v);
            if (tbl_inst[i].rd != '0) begin
                model_regs[tbl_inst[i].rd] = v;
            end
        end
    endtask

    // entered and left on a falling edge
    task automatic offer_inst(input sb_pkg::inst_t row);
        int waited;
        waited = 0;
        while (stall && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (stall) begin
            $display("stall stayed high for %0d cycles, pc %h never offered", TIMEOUT, row.pc);
            timed_out = 1'b1;
            error_count++;
        end else begin
            inst_valid = 1'b1;
            inst_pc = row.pc;
            inst_unit = row.unit;
            inst_op = row.op;
            inst_rd = row.rd;
            inst_rs1 = row.rs1;
            inst_rs1_en = row.rs1_en;
            inst_rs2 = row.rs2;
            inst_rs2_en = row.rs2_en;
            inst_imm = row.imm;
            @(negedge clk);
            inst_valid = 1'b0;
        end
    endtask

    task automatic run_table(input string name, input logic want_stall);
        int errs_before;
        int start;
        int stall_start;
        int waited;
        int n;
        errs_before = error_count;
        start = mon_pc.size();
        stall_start = stall_cycles;
        n = tbl_inst.size();
        fill_expected();
        foreach (tbl_inst[i]) begin
            offer_inst(tbl_inst[i]);
        end
        waited = 0;
        while (mon_pc.size() - start < n && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (mon_pc.size() - start < n) begin
            $display("%s: only %0d of %0d instructions retired before the timeout",
                     name, mon_pc.size() - start, n);
            timed_out = 1'b1;
            error_count++;
        end else begin
            // quiet window to catch a repeated retire
            repeat (20) @(posedge clk);
            check_word({name, " retire count"}, sb_pkg::word_t'(n),
                       sb_pkg::word_t'(mon_pc.size() - start));
            for (int i = 0; i < n; i++) begin
                check_word($sformatf("%s[%0d] pc", name, i), tbl_inst[i].pc, mon_pc[start + i]);
                check_reg($sformatf("%s[%0d] rd", name, i), tbl_inst[i].rd, mon_rd[start + i]);
                check_word($sformatf("%s[%0d] value", name, i), tbl_val[i], mon_val[start + i]);
            end
            if (want_stall && stall_cycles == stall_start) begin
                $display("%s: stall never went high during the burst", name);
                error_count++;
            end
        end
        @(negedge clk);
        report_test(name, errs_before);
        tbl_inst.delete();
        tbl_val.delete();
    endtask

    initial begin
        int errs;
        int r;
        resetn = 1'b0;
        inst_valid = 1'b0;
        inst_pc = '0;
        inst_unit = u0;
        inst_op = sb_pkg::op_add;
        inst_rd = '0;
        inst_rs1 = '0;
        inst_rs1_en = 1'b0;
        inst_rs2 = '0;
        inst_rs2_en = 1'b0;
        inst_imm = '0;
        seed = 32'h1644;
        error_count = 0;
        test_count = 0;
        failed_tests = 0;
        timed_out = 1'b0;
        next_pc = 32'h0000_1000;
        for (int i = 0; i < `SB_NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(negedge clk);
        resetn = 1'b1;

        errs = error_count;
        @(negedge clk);
        check_bit("reset_idle stall", 1'b0, stall);
        check_bit("reset_idle wen", 1'b0, debug_wb_rf_wen);
        repeat (20) @(negedge clk);
        check_word("reset_idle pulses", '0, sb_pkg::word_t'(mon_pc.size()));
        check_word("reset_idle stall cycles", '0, sb_pkg::word_t'(stall_cycles));
        report_test("reset_idle", errs);

        // odd registers get negative immediates
        for (int i = 1; i < 8; i++) begin
            add_row(i[0] ? u1 : u0, sb_pkg::op_add, i, 0, 1'b1, 0, 1'b0,
                    {i[0] ? 4'hf : 4'h0, 12'(i * 291)});
        end
        run_table("imm_loads", 1'b0);

        add_row(u0, sb_pkg::op_add, 1, 1, 1'b1, 0, 1'b0, 16'd100);
        add_row(u1, sb_pkg::op_sub, 2, 1, 1'b1, 7, 1'b1, 16'h0);
        add_row(u0, sb_pkg::op_and, 3, 2, 1'b1, 0, 1'b0, 16'h0ff0);
        add_row(u1, sb_pkg::op_or, 4, 3, 1'b1, 1, 1'b1, 16'h0);
        add_row(u0, sb_pkg::op_xor, 5, 4, 1'b1, 0, 1'b0, 16'hffff);
        add_row(u1, sb_pkg::op_slt, 6, 5, 1'b1, 4, 1'b1, 16'h0);
        add_row(u0, sb_pkg::op_slt, 6, 6, 1'b1, 0, 1'b0, 16'h0005);
        add_row(u1, sb_pkg::op_sll, 7, 4, 1'b1, 0, 1'b0, 16'h0003);
        add_row(u0, sb_pkg::op_srl, 1, 5, 1'b1, 7, 1'b1, 16'h0);
        add_row(u1, sb_pkg::op_sub, 3, 0, 1'b0, 2, 1'b1, 16'h0);
        add_row(u0, sb_pkg::op_add, 2, 1, 1'b1, 3, 1'b1, 16'h0);
        run_table("alu_chain", 1'b0);

        for (int i = 0; i < 20; i++) begin
            add_row(i[0] ? u1 : u0, sb_pkg::op_add, 1 + i % 7, 1 + (i + 6) % 7, 1'b1,
                    0, 1'b0, 16'(i + 1));
        end
        run_table("burst", 1'b1);

        add_row(u0, sb_pkg::op_add, 0, 0, 1'b1, 0, 1'b0, 16'h0055);
        add_row(u1, sb_pkg::op_add, 1, 0, 1'b1, 0, 1'b1, 16'h7777);
        add_row(u0, sb_pkg::op_add, 2, 0, 1'b1, 0, 1'b0, 16'h0001);
        add_row(u1, sb_pkg::op_add, 2, 0, 1'b1, 0, 1'b0, 16'h0002);
        add_row(u0, sb_pkg::op_add, 2, 2, 1'b1, 0, 1'b0, 16'h0003);
        add_row(u1, sb_pkg::op_or, 3, 0, 1'b1, 2, 1'b1, 16'h0);
        run_table("r0_and_rewrite", 1'b0);

        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            add_row(sb_pkg::unit_t'(r[0]), sb_pkg::alu_op_t'(r[3:1]), (r >> 4) & 7,
                    (r >> 7) & 7, r[10], (r >> 11) & 7, r[14], r[31:16]);
        end
        run_table("random", 1'b0);

        $display("summary: %0d tests run, %0d with errors, %0d check errors",
                 test_count, failed_tests, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
